// ==== verification/mips_tests.txt ====
// P <instruction word, hex>, loaded from address 0
// S <data word address, hex> <expected store data, hex>, in store order
P 20010005
P 2002FFFD
P 00221820
P AC030000
P 00222022
P AC040004
P 00222824
P AC050008
P 00223025
P AC06000C
P 0041382A
P AC070010
P 00014100
P 00084882
P AC090014
P 20000007
P AC000018
P AC0601F8
P 8C0A01F8
P AC0A001C
P 10210001
P AC010020
P 14210001
P AC010024
P 0C00001C
P FC02FFFF
P AC020028
P 0800001B
P AC1F002C
P 03E00008
S 00 00000002
S 01 00000008
S 02 00000005
S 03 FFFFFFFD
S 04 00000001
S 05 00000014
S 06 00000000
S 7E FFFFFFFD
S 07 FFFFFFFD
S 09 00000005
S 0B 00000064
S 0A FFFFFFFD

// ==== filelist.f ====
logic/mipsPkg.sv
logic/decodeIf.sv
logic/mainDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/pcUnit.sv
logic/singleCycleMips.sv
verification/singleCycleMips_props.sv
verification/singleCycleMips_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module singleCycleMips_tb -o simv \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "*** TEST FAILED ***" >> sim.log
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

// ==== verification/singleCycleMips_tb.sv ====
`timescale 1ns/1ps

module singleCycleMips_tb;

    localparam int IMEM_WORDS = 32;
    localparam int DMEM_WORDS = 128;
    localparam string TEST_FILE = "verification/mips_tests.txt";

    logic        clk = 1'b0;
    logic        rst_n = 1'b1;
    logic [31:0] instr;
    logic [31:0] memReadData;
    logic [31:0] instrAddr;
    logic        memCen;
    logic        memWen;
    logic        memOen;
    logic [6:0]  memAddr;
    logic [31:0] memWriteData;

    // Memory models
    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];

    // Expected stores, in program order
    logic [6:0]  expAddr [$];
    logic [31:0] expData [$];
    int          numWords = 0;
    int          storeIdx = 0;
    int          cycleCount = 0;
    int          timeoutLimit = 50;
    logic [31:0] prevAddr = '0;
    bit          havePrev = 1'b0;

    singleCycleMips #(
        .DMEM_ADDR_W (7),
        .RESET_PC    ('0)
    ) singleCycleMips_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .memReadData  (memReadData),
        .instrAddr    (instrAddr),
        .memCen       (memCen),
        .memWen       (memWen),
        .memOen       (memOen),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    // Both memories answer in the same cycle
    assign instr       = imem[instrAddr[6:2]];
    assign memReadData = memOen ? '0 : dmem[memAddr];

    // Store lands at the edge that ends the sw cycle
    always @(posedge clk) begin
        if (!rst_n && !memCen && !memWen) begin
            dmem[memAddr] <= memWriteData;
        end
    end

    task automatic abortRun;
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // Tagged lines: P program word, S word address and data
    task automatic loadTests;
        int          fd;
        string       line;
        logic [31:0] valA;
        logic [31:0] valB;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the test file %s", TEST_FILE);
            abortRun();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    if ($sscanf(line, "P %h", valA) == 1) begin
                        assert (numWords < IMEM_WORDS) else begin
                            $display("Program does not fit the instruction memory");
                            abortRun();
                        end
                        imem[numWords] = valA;
                        numWords++;
                    end else if ($sscanf(line, "S %h %h", valA, valB) == 2) begin
                        expAddr.push_back(valA[6:0]);
                        expData.push_back(valB);
                    end
                end
            end
            $fclose(fd);
            // Generous per-instruction budget plus reset
            timeoutLimit = 8 * numWords + 50;
        end
    endtask

    task automatic checkStore(input logic [6:0] addr, input logic [31:0] data);
        assert (storeIdx < expAddr.size()) else begin
            $display("Store to word %0h after all expected stores were seen", addr);
            abortRun();
        end
        assert (addr == expAddr[storeIdx]) else begin
            $display("Fail at %0t ns: memAddr expected %h, got %h",
                     $time, expAddr[storeIdx], addr);
            abortRun();
        end
        assert (data == expData[storeIdx]) else begin
            $display("Fail at %0t ns: memWriteData expected %h, got %h",
                     $time, expData[storeIdx], data);
            abortRun();
        end
        storeIdx++;
    endtask

    // Chip selected only for lw (0x23) and sw (0x2B)
    task automatic checkChipEnable(input logic [5:0] opcode);
        logic expCen;
        expCen = !(opcode == 6'h23 || opcode == 6'h2B);
        assert (memCen == expCen) else begin
            $display("Fail at %0t ns: memCen expected %b, got %b",
                     $time, expCen, memCen);
            abortRun();
        end
    endtask

    // Halt loop reached, every store must have been seen
    task automatic finishRun;
        if (storeIdx == expAddr.size()) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("Program halted after %0d of %0d expected stores",
                     storeIdx, expAddr.size());
            abortRun();
        end
    endtask

    initial begin
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
        loadTests();
    end

    initial begin
        forever #50 clk = ~clk;
    end

    // Reset for 10 cycles, released just after an edge
    initial begin
        repeat (10) @(posedge clk);
        #5 rst_n = 1'b0;
    end

    always @(posedge clk) begin
        cycleCount++;
        assert (cycleCount <= timeoutLimit) else begin
            $display("Timeout: the program never reached its halt loop");
            abortRun();
        end
    end

    // Strobes and PC stable mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            havePrev = 1'b0;
        end else begin
            checkChipEnable(instr[31:26]);
            if (!memCen && !memWen) begin
                checkStore(memAddr, memWriteData);
            end
            // Same address twice means the self-jump
            if (havePrev && instrAddr == prevAddr) begin
                finishRun();
            end else begin
                prevAddr = instrAddr;
                havePrev = 1'b1;
            end
        end
    end

endmodule

// ==== verification/singleCycleMips_props.sv ====
`timescale 1ns/1ps

module singleCycleMips_props (
    input logic        clk,
    input logic        rst_n,
    input logic        memCen,
    input logic        memWen,
    input logic        memOen,
    input logic [31:0] instrAddr
);

    // A write needs the chip selected
    wenNeedsCen: assert property (@(posedge clk) disable iff (rst_n) !memWen |-> !memCen)
        else $error("memWen low while memCen is high");

    // Write and output drive are exclusive
    wenOenExclusive: assert property (@(posedge clk) disable iff (rst_n) memWen || memOen)
        else $error("memWen and memOen both low");

    // Fetch address stays word aligned
    pcAligned: assert property (@(posedge clk) disable iff (rst_n) instrAddr[1:0] == 2'b00)
        else $error("instrAddr not word aligned");

endmodule

bind singleCycleMips singleCycleMips_props singleCycleMips_props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .memCen    (memCen),
    .memWen    (memWen),
    .memOen    (memOen),
    .instrAddr (instrAddr)
);

// ==== logic/singleCycleMips.sv ====
`timescale 1ns/1ps

module singleCycleMips import mipsPkg::*; #(
    parameter int DMEM_ADDR_W = 7,
    parameter logic [DATA_W-1:0] RESET_PC = '0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [31:0]            instr,
    input  logic [31:0]            memReadData,
    output logic [31:0]            instrAddr,
    output logic                   memCen,
    output logic                   memWen,
    output logic                   memOen,
    output logic [DMEM_ADDR_W-1:0] memAddr,
    output logic [31:0]            memWriteData
);

    // Instruction fields
    opcodeT               instrOp;
    functT                instrFunct;
    logic [REG_IDX_W-1:0] rsIdx;
    logic [REG_IDX_W-1:0] rtIdx;
    logic [REG_IDX_W-1:0] rdIdx;
    logic [4:0]           shamt;
    logic [15:0]          immediate;
    logic [25:0]          jumpTarget;

    // Datapath nets
    logic [DATA_W-1:0] rsData;
    logic [DATA_W-1:0] rtData;
    logic [DATA_W-1:0] aluResult;
    logic [DATA_W-1:0] pcPlus4;
    logic              equal;

    decodeIf ctrl ();

    // Field split, unknown codes pass through to the decoder default
    assign instrOp    = opcodeT'(instr[31:26]);
    assign rsIdx      = instr[25:21];
    assign rtIdx      = instr[20:16];
    assign rdIdx      = instr[15:11];
    assign shamt      = instr[10:6];
    assign instrFunct = functT'(instr[5:0]);
    assign immediate  = instr[15:0];
    assign jumpTarget = instr[25:0];

    mainDecoder mainDecoder_i (
        .instrOp    (instrOp),
        .instrFunct (instrFunct),
        .ctrl       (ctrl.decoder)
    );

    regFile regFile_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rsIdx       (rsIdx),
        .rtIdx       (rtIdx),
        .rdIdx       (rdIdx),
        .aluResult   (aluResult),
        .memReadData (memReadData),
        .linkAddr    (pcPlus4),
        .ctrl        (ctrl.regs),
        .rsData      (rsData),
        .rtData      (rtData)
    );

    alu alu_i (
        .rsData    (rsData),
        .rtData    (rtData),
        .immediate (immediate),
        .shamt     (shamt),
        .ctrl      (ctrl.exec),
        .aluResult (aluResult),
        .equal     (equal)
    );

    pcUnit #(
        .RESET_PC (RESET_PC)
    ) pcUnit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .jumpTarget   (jumpTarget),
        .branchOffset (immediate),
        .rsData       (rsData),
        .equal        (equal),
        .ctrl         (ctrl.flow),
        .pc           (instrAddr),
        .pcPlus4      (pcPlus4)
    );

    // Active-low strobes, chip enabled only for lw and sw
    assign memCen = ~(ctrl.memRead | ctrl.memWrite);
    assign memWen = ~ctrl.memWrite;
    // Memory drives data except during a store
    assign memOen = ctrl.memWrite;
    // Word address straight from the ALU result
    assign memAddr      = aluResult[DMEM_ADDR_W+1:2];
    assign memWriteData = rtData;

endmodule

// ==== logic/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit import mipsPkg::*; #(
    parameter logic [DATA_W-1:0] RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [25:0]       jumpTarget,
    input  logic [15:0]       branchOffset,
    input  logic [DATA_W-1:0] rsData,
    input  logic              equal,
    decodeIf.flow             ctrl,
    output logic [DATA_W-1:0] pc,
    output logic [DATA_W-1:0] pcPlus4
);

    logic [DATA_W-1:0] jumpAddr;
    logic [DATA_W-1:0] branchAddr;
    logic [DATA_W-1:0] nextPc;
    logic              branchTaken;

    assign pcPlus4 = pc + 4;
    // Region bits from pc+4, word-aligned target
    assign jumpAddr = {pcPlus4[DATA_W-1:28], jumpTarget, 2'b00};
    // Offset counted in words from pc+4
    assign branchAddr = pcPlus4 + {{(DATA_W - 18){branchOffset[15]}}, branchOffset, 2'b00};
    // beq taken on equal, bne on not equal
    assign branchTaken = ctrl.branch && (equal != ctrl.branchNe);

    // Priority jump, jr, branch, sequential
    always_comb begin
        if (ctrl.jump) begin
            nextPc = jumpAddr;
        end else if (ctrl.jumpReg) begin
            nextPc = rsData;
        end else if (branchTaken) begin
            nextPc = branchAddr;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu import mipsPkg::*; (
    input  logic [DATA_W-1:0] rsData,
    input  logic [DATA_W-1:0] rtData,
    input  logic [15:0]       immediate,
    input  logic [4:0]        shamt,
    decodeIf.exec             ctrl,
    output logic [DATA_W-1:0] aluResult,
    output logic              equal
);

    logic [DATA_W-1:0] immExt;
    logic [DATA_W-1:0] operandB;

    // Sign-extended immediate for addi, lw, sw
    assign immExt = {{(DATA_W - 16){immediate[15]}}, immediate};

    // Second operand mux
    always_comb begin
        case (ctrl.aluSrc)
            srcImm:   operandB = immExt;
            srcShamt: operandB = {{(DATA_W - 5){1'b0}}, shamt};
            default:  operandB = rtData;
        endcase
    end

    always_comb begin
        aluResult = '0;
        case (ctrl.aluOp)
            aluAdd: aluResult = rsData + operandB;
            aluSub: aluResult = rsData - operandB;
            aluAnd: aluResult = rsData & operandB;
            aluOr:  aluResult = rsData | operandB;
            aluNor: aluResult = ~(rsData | operandB);
            aluSlt: begin
                // Signed compare, result in bit 0
                aluResult[0] = $signed(rsData) < $signed(operandB);
            end
            aluSll: begin
                // Shifts operate on rt, amount from shamt
                aluResult = rtData << operandB[4:0];
            end
            aluSrl: begin
                // Logical right shift, zero fill
                aluResult = rtData >> operandB[4:0];
            end
            default: aluResult = '0;
        endcase
    end

    // Raw equality of rs and rt
    // beq/bne polarity is applied in pcUnit
    assign equal = (rsData == rtData);

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [REG_IDX_W-1:0] rsIdx,
    input  logic [REG_IDX_W-1:0] rtIdx,
    input  logic [REG_IDX_W-1:0] rdIdx,
    input  logic [DATA_W-1:0]    aluResult,
    input  logic [DATA_W-1:0]    memReadData,
    input  logic [DATA_W-1:0]    linkAddr,
    decodeIf.regs                ctrl,
    output logic [DATA_W-1:0]    rsData,
    output logic [DATA_W-1:0]    rtData
);

    // Register 0 has no storage
    logic [DATA_W-1:0] regs [1:31];
    logic [REG_IDX_W-1:0] dstIdx;
    logic [DATA_W-1:0] writeData;

    // Destination select, rd before $31 before rt
    always_comb begin
        if (ctrl.regDst) begin
            dstIdx = rdIdx;
        end else if (ctrl.link) begin
            dstIdx = '1;
        end else begin
            dstIdx = rtIdx;
        end
    end

    // Write-back data select
    always_comb begin
        if (ctrl.memToReg) begin
            writeData = memReadData;
        end else if (ctrl.link) begin
            writeData = linkAddr;
        end else begin
            writeData = aluResult;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && dstIdx != '0) begin
            // Writes to $0 are dropped
            regs[dstIdx] <= writeData;
        end
    end

    // Combinational reads, $0 reads zero
    assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
    assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule

// ==== logic/mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder import mipsPkg::*; (
    input  opcodeT          instrOp,
    input  functT           instrFunct,
    decodeIf.decoder        ctrl
);

    always_comb begin
        // No-op pattern as default
        // Nothing written, nothing stored, sequential flow
        ctrl.regDst   = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.link     = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.branchNe = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.jumpReg  = 1'b0;
        ctrl.aluSrc   = srcReg;
        ctrl.aluOp    = aluAdd;
        case (instrOp)
            opRType: begin
                // Writes rd, ALU op comes from funct
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instrFunct)
                    fnAdd: ctrl.aluOp = aluAdd;
                    fnSub: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr:  ctrl.aluOp = aluOr;
                    fnSlt: ctrl.aluOp = aluSlt;
                    fnSll: begin
                        ctrl.aluSrc = srcShamt;
                        ctrl.aluOp  = aluSll;
                    end
                    fnSrl: begin
                        ctrl.aluSrc = srcShamt;
                        ctrl.aluOp  = aluSrl;
                    end
                    fnJr: begin
                        // Jump to rs, no register write
                        ctrl.regDst   = 1'b0;
                        ctrl.regWrite = 1'b0;
                        ctrl.jumpReg  = 1'b1;
                    end
                    default: begin
                        // Unknown funct behaves as no-op
                        ctrl.regDst   = 1'b0;
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
            opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = srcImm;
            end
            opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = srcImm;
            end
            opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = srcImm;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
            end
            opBne: begin
                // Polarity resolved in pcUnit
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = aluSub;
            end
            opJ: ctrl.jump = 1'b1;
            opJal: begin
                // Return address into $31
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/decodeIf.sv ====
`timescale 1ns/1ps

// Decoded control bundle, decoder to datapath units
interface decodeIf import mipsPkg::*; ();
    // Register write-back control
    logic regDst;
    logic regWrite;
    logic memToReg;
    logic link;
    // Memory strobes, consumed at top level
    logic memRead;
    logic memWrite;
    // Program flow
    logic branch;
    logic branchNe;
    logic jump;
    logic jumpReg;
    // Execute stage
    aluSrcT aluSrc;
    aluOpT aluOp;

    modport decoder (
        output regDst, regWrite, memToReg, link, memRead, memWrite,
        output branch, branchNe, jump, jumpReg, aluSrc, aluOp
    );
    modport regs (input regDst, regWrite, memToReg, link);
    modport exec (input aluSrc, aluOp);
    modport flow (input branch, branchNe, jump, jumpReg);
endinterface

// ==== logic/mipsPkg.sv ====
package mipsPkg;

    // Datapath word and register number widths
    localparam int DATA_W = 32;
    localparam int REG_IDX_W = 5;

    // Major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcodeT;

    // R-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2A
    } functT;

    // ALU operations
    // aluNor is implemented but no instruction selects it
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluNor,
        aluSll,
        aluSrl
    } aluOpT;

    // Second ALU operand source
    typedef enum logic [1:0] {
        srcReg,
        srcImm,
        srcShamt
    } aluSrcT;

endpackage
